// File: bench/fdiv_props.sv
`timescale 1ns/1ns

module fdiv_props
    import fdiv_pkg::*;
(
    input logic       clk,
    input logic       rst,
    input logic       out_valid,
    input logic       out_ready,
    input fdiv_resp_t out_resp,
    input logic       iter_in_valid,
    input logic       iter_in_ready,
    input logic       iter_out_valid,
    input logic       iter_out_ready
);

    int   violations = 0;
    logic iter_busy;

    // High from the iterate accept edge until its result moves on.
    always_ff @(posedge clk) begin
        if (rst) begin
            iter_busy <= 1'b0;
        end else if (iter_in_valid && iter_in_ready) begin
            iter_busy <= 1'b1;
        end else if (iter_out_valid && iter_out_ready) begin
            iter_busy <= 1'b0;
        end
    end

    held_output: assert property (
        @(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_resp)
    ) else begin
        violations = violations + 1;
        $error("output valid or payload changed while stalled");
    end

    reset_clears_output: assert property (
        @(posedge clk) rst |=> !out_valid
    ) else begin
        violations = violations + 1;
        $error("output valid high in the cycle after reset");
    end

    single_division: assert property (
        @(posedge clk) disable iff (rst)
        iter_busy |-> !iter_in_ready
    ) else begin
        violations = violations + 1;
        $error("iterate stage ready while a division is in progress");
    end

endmodule

bind fdiv_unit fdiv_props props_inst (
    .clk(clk),
    .rst(rst),
    .out_valid(out_valid),
    .out_ready(out_ready),
    .out_resp(out_resp),
    .iter_in_valid(exp_valid),
    .iter_in_ready(exp_ready),
    .iter_out_valid(quot_valid),
    .iter_out_ready(quot_ready)
);

// File: bench/fdiv_tb.sv
`timescale 1ns/1ns

module fdiv_tb
    import fdiv_pkg::*;
();

    // 21 divisions at about 30 cycles each, plus reset and stalls, stay near 900 cycles.
    localparam int MAX_CYCLES    = 2000;
    localparam int RESPONSE_WAIT = 300;
    // One cycle each for the exponent, normalize and output registers, and 27
    // for the iterate stage.
    localparam int LATENCY       = 30;
    localparam int MIN_SPACING   = 27;

    // Flag bits in fflags order.
    localparam logic [4:0] NV = 5'b10000;
    localparam logic [4:0] DZ = 5'b01000;
    localparam logic [4:0] OF = 5'b00100;
    localparam logic [4:0] UF = 5'b00010;
    localparam logic [4:0] NX = 5'b00001;

    typedef struct packed {
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] result;
        logic [4:0]  flags;
    } div_case_t;

    logic       clk = 1'b0;
    logic       rst;
    logic       in_valid;
    logic       in_ready;
    fdiv_req_t  in_req;
    logic       out_valid;
    logic       out_ready;
    fdiv_resp_t out_resp;

    integer     seed;
    int         cycle_count = 0;
    int         error_count = 0;
    int         test_count = 0;
    int         failed_tests = 0;
    div_case_t  cases[$];
    int         accept_cycles[$];
    int         response_cycles[$];

    fdiv_unit #(
        .OUTPUT_REGISTER(1)
    ) DUT (
        .clk, .rst,
        .in_valid, .in_ready, .in_req,
        .out_valid, .out_ready, .out_resp
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Run stopped at %0d cycles because the DUT stopped answering.", MAX_CYCLES);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    task automatic add_case(input logic [31:0] a, input logic [31:0] b,
                            input logic [31:0] result, input logic [4:0] flags);
        cases.push_back('{a, b, result, flags});
    endtask

    task automatic report_mismatch(input string name, input string what, input int index,
                                   input logic [31:0] expected, input logic [31:0] actual);
        $display("[ERROR] %s: division %0d %s expected %h, actual %h",
                 name, index, what, expected, actual);
        error_count++;
    endtask

    // Called and left right after a falling edge.
    task automatic send_request(input div_case_t c, input logic [4:0] tag);
        in_req.a   = c.a;
        in_req.b   = c.b;
        in_req.tag = tag;
        in_valid   = 1'b1;
        while (!in_ready) begin
            @(negedge clk);
        end
        accept_cycles.push_back(cycle_count);
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic receive_response(input bit stall, output fdiv_resp_t resp, output bit got);
        int     waited;
        integer draw;
        waited = 0;
        got    = 1'b0;
        while (!got && waited < RESPONSE_WAIT) begin
            draw      = $random(seed);
            out_ready = stall ? draw[0] : 1'b1;
            if (out_valid && out_ready) begin
                resp = out_resp;
                got  = 1'b1;
                response_cycles.push_back(cycle_count);
            end
            @(negedge clk);
            waited++;
        end
    endtask

    task automatic run_cases(input string name, input bit stall);
        logic [4:0] tags[$];
        fdiv_resp_t resp;
        bit         got;
        int         i;
        int         j;
        integer     draw;
        accept_cycles.delete();
        response_cycles.delete();
        for (i = 0; i < cases.size(); i++) begin
            draw = $random(seed);
            tags.push_back(draw[4:0]);
        end
        fork
            begin
                for (i = 0; i < cases.size(); i++) begin
                    send_request(cases[i], tags[i]);
                end
            end
            begin
                if (stall) begin
                    // Long enough for two results to pile up in the output stage.
                    out_ready = 1'b0;
                    repeat (2 * LATENCY + 4) @(negedge clk);
                end
                for (j = 0; j < cases.size(); j++) begin
                    receive_response(stall, resp, got);
                    if (!got) begin
                        $display("%s: no response for division %0d within %0d cycles",
                                 name, j, RESPONSE_WAIT);
                        error_count++;
                        break;
                    end
                    if (resp.result !== cases[j].result) begin
                        report_mismatch(name, "result", j, cases[j].result, resp.result);
                    end
                    if (resp.flags !== cases[j].flags) begin
                        report_mismatch(name, "flags", j, {27'd0, cases[j].flags},
                                        {27'd0, resp.flags});
                    end
                    if (resp.tag !== tags[j]) begin
                        report_mismatch(name, "tag", j, {27'd0, tags[j]}, {27'd0, resp.tag});
                    end
                end
            end
        join
        out_ready = 1'b1;
        repeat (4) begin
            if (out_valid) begin
                $display("%s: a response came after all divisions were answered", name);
                error_count++;
            end
            @(negedge clk);
        end
        out_ready = 1'b0;
    endtask

    task automatic finish_test(input string name, input int errors_before);
        test_count++;
        if (error_count == errors_before) begin
            $display("test %s: passed", name);
        end else begin
            failed_tests++;
            $display("test %s: failed with %0d errors", name, error_count - errors_before);
        end
    endtask

    task automatic test_exact_quotients();
        int errors_before;
        errors_before = error_count;
        cases.delete();
        add_case(32'h40c00000, 32'h40400000, 32'h40000000, 5'b0);
        add_case(32'hbf800000, 32'h40800000, 32'hbe800000, 5'b0);
        run_cases("exact_quotients", 1'b0);
        finish_test("exact_quotients", errors_before);
    endtask

    task automatic test_rounding();
        int errors_before;
        errors_before = error_count;
        cases.delete();
        add_case(32'h3f800000, 32'h40400000, 32'h3eaaaaab, NX);
        add_case(32'h40000000, 32'h40400000, 32'h3f2aaaab, NX);
        run_cases("rounding", 1'b0);
        finish_test("rounding", errors_before);
    endtask

    task automatic test_special_cases();
        int errors_before;
        errors_before = error_count;
        cases.delete();
        add_case(32'h3f800000, 32'h00000000, 32'h7f800000, DZ);
        add_case(32'hbf800000, 32'h00000000, 32'hff800000, DZ);
        add_case(32'h00000000, 32'h00000000, 32'h7fc00000, NV);
        add_case(32'h7f800000, 32'hff800000, 32'h7fc00000, NV);
        add_case(32'h7f800000, 32'h40000000, 32'h7f800000, 5'b0);
        add_case(32'h40400000, 32'h7f800000, 32'h00000000, 5'b0);
        add_case(32'h7fc00000, 32'h3f800000, 32'h7fc00000, 5'b0);
        // Signaling NaN operand.
        add_case(32'h7f800001, 32'h3f800000, 32'h7fc00000, NV);
        run_cases("special_cases", 1'b0);
        finish_test("special_cases", errors_before);
    endtask

    task automatic test_range_limits();
        int errors_before;
        errors_before = error_count;
        cases.delete();
        add_case(32'h7f7fffff, 32'h3f000000, 32'h7f800000, OF | NX);
        add_case(32'h00800000, 32'h40800000, 32'h00000000, UF | NX);
        run_cases("range_limits", 1'b0);
        finish_test("range_limits", errors_before);
    endtask

    task automatic test_latency_throughput();
        int errors_before;
        int latency;
        int spacing;
        int i;
        errors_before = error_count;
        cases.delete();
        add_case(32'h3fc00000, 32'h3f000000, 32'h40400000, 5'b0);
        run_cases("latency", 1'b0);
        if (response_cycles.size() == 1) begin
            latency = response_cycles[0] - accept_cycles[0];
            if (latency != LATENCY) begin
                report_mismatch("latency", "cycles", 0, LATENCY, latency);
            end
        end
        cases.delete();
        add_case(32'h41200000, 32'h40800000, 32'h40200000, 5'b0);
        add_case(32'hc1100000, 32'h40400000, 32'hc0400000, 5'b0);
        add_case(32'h3fc00000, 32'h3f000000, 32'h40400000, 5'b0);
        run_cases("throughput", 1'b0);
        for (i = 1; i < response_cycles.size(); i++) begin
            spacing = response_cycles[i] - response_cycles[i - 1];
            if (spacing < MIN_SPACING) begin
                $display("[ERROR] throughput: spacing expected at least %0d, actual %0d",
                         MIN_SPACING, spacing);
                error_count++;
            end
        end
        finish_test("latency_throughput", errors_before);
    endtask

    task automatic test_back_pressure();
        int errors_before;
        errors_before = error_count;
        cases.delete();
        add_case(32'h3f800000, 32'h40400000, 32'h3eaaaaab, NX);
        add_case(32'h40e00000, 32'h40000000, 32'h40600000, 5'b0);
        add_case(32'h7f7fffff, 32'h3f000000, 32'h7f800000, OF | NX);
        run_cases("back_pressure", 1'b1);
        finish_test("back_pressure", errors_before);
    endtask

    initial begin
        seed      = 32'hf9f;
        rst       = 1'b1;
        in_valid  = 1'b0;
        in_req    = '0;
        out_ready = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        test_exact_quotients();
        test_rounding();
        test_special_cases();
        test_range_limits();
        test_latency_throughput();
        test_back_pressure();

        $display("tests run: %0d, tests failed: %0d, errors: %0d, assertion failures: %0d",
                 test_count, failed_tests, error_count, DUT.props_inst.violations);
        if (error_count == 0 && failed_tests == 0 && DUT.props_inst.violations == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: filelist.f
source/fdiv_pkg.sv
source/fdiv_exponent.sv
source/fdiv_iterate.sv
source/fdiv_normalize.sv
source/fdiv_output_stage.sv
source/fdiv_unit.sv
bench/fdiv_props.sv
bench/fdiv_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module fdiv_tb -Mdir build -f filelist.f

./build/Vfdiv_tb +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
    echo "Simulation reported a failure."
    exit 1
fi
if ! grep -q "TEST RESULT: PASS" sim.log; then
    echo "Simulation ended without a result line."
    exit 1
fi
echo "Simulation finished cleanly."

// File: source/fdiv_exponent.sv
`timescale 1ns/1ns

module fdiv_exponent
    import fdiv_pkg::*;
(
    input  logic      clk,
    input  logic      rst,

    input  logic      in_valid,
    output logic      in_ready,
    input  fdiv_req_t in_req,

    output logic      out_valid,
    input  logic      out_ready,
    output fdiv_exp_t out_exp
);

    typedef struct packed {
        logic zero;
        logic inf;
        logic qnan;
        logic snan;
    } op_class_t;

    // Subnormals have a zero exponent field and count as zero.
    function automatic op_class_t classify(input logic [31:0] op);
        op_class_t c;
        c.zero = (op[30:23] == 8'h00);
        c.inf  = (op[30:23] == 8'hff) && (op[22:0] == '0);
        c.qnan = (op[30:23] == 8'hff) && op[22];
        c.snan = (op[30:23] == 8'hff) && !op[22] && (op[21:0] != '0);
        return c;
    endfunction

    op_class_t     cls_a, cls_b;
    fdiv_special_e special;
    fdiv_exp_t     next_exp;

    assign cls_a = classify(in_req.a);
    assign cls_b = classify(in_req.b);

    always_comb begin
        if (cls_a.snan || cls_b.snan) begin
            special = SPECIAL_NAN_INVALID;
        end else if (cls_a.qnan || cls_b.qnan) begin
            special = SPECIAL_NAN_QUIET;
        end else if ((cls_a.zero && cls_b.zero) || (cls_a.inf && cls_b.inf)) begin
            special = SPECIAL_NAN_INVALID;
        end else if (cls_a.inf) begin
            special = SPECIAL_INF;
        end else if (cls_b.zero) begin
            special = SPECIAL_DIV_ZERO;
        end else if (cls_a.zero || cls_b.inf) begin
            special = SPECIAL_ZERO;
        end else begin
            special = SPECIAL_NONE;
        end
    end

    always_comb begin
        next_exp.sign    = in_req.a[31] ^ in_req.b[31];
        next_exp.exp     = signed'({2'b00, in_req.a[30:23]})
                         - signed'({2'b00, in_req.b[30:23]}) + EXP_BIAS;
        next_exp.mant_a  = {1'b1, in_req.a[22:0]};
        next_exp.mant_b  = {1'b1, in_req.b[22:0]};
        next_exp.special = special;
        next_exp.tag     = in_req.tag;
    end

    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end

        if (in_valid && in_ready) begin
            out_exp <= next_exp;
        end
    end

endmodule

// File: source/fdiv_iterate.sv
`timescale 1ns/1ns

module fdiv_iterate
    import fdiv_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    input  logic       in_valid,
    output logic       in_ready,
    input  fdiv_exp_t  in_exp,

    output logic       out_valid,
    input  logic       out_ready,
    output fdiv_quot_t out_quot
);

    logic [4:0]           counter;
    logic                 accept, advance, last;

    logic [24:0]          rem, step_rem, rem_sub, next_rem;
    logic [23:0]          divisor, step_div;
    logic [26:0]          quot, step_quot, next_quot;
    logic                 ge;

    logic                 hold_sign;
    logic signed [9:0]    hold_exp;
    fdiv_special_e        hold_special;
    logic [TAG_WIDTH-1:0] hold_tag;

    // Idle means no step in progress and no result waiting.
    assign in_ready = (counter == '0) && !out_valid;
    assign accept   = in_valid && in_ready;
    assign advance  = accept || (counter != '0);
    assign last     = (counter == 5'(ITER_STEPS - 1));

    always_comb begin
        if (counter == '0) begin
            step_rem  = {1'b0, in_exp.mant_a};
            step_div  = in_exp.mant_b;
            step_quot = '0;
        end else begin
            step_rem  = rem;
            step_div  = divisor;
            step_quot = quot;
        end

        // One restoring step yields one quotient bit.
        ge        = step_rem >= {1'b0, step_div};
        rem_sub   = ge ? step_rem - {1'b0, step_div} : step_rem;
        next_rem  = rem_sub << 1;
        next_quot = {step_quot[25:0], ge};
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            counter   <= '0;
            out_valid <= 1'b0;
        end else begin
            if (advance) begin
                counter <= last ? '0 : counter + 5'd1;
            end

            if (advance && last) begin
                out_valid <= 1'b1;
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
        end

        if (advance) begin
            rem  <= next_rem;
            quot <= next_quot;
        end

        if (accept) begin
            divisor      <= in_exp.mant_b;
            hold_sign    <= in_exp.sign;
            hold_exp     <= in_exp.exp;
            hold_special <= in_exp.special;
            hold_tag     <= in_exp.tag;
        end
    end

    always_comb begin
        out_quot.sign    = hold_sign;
        out_quot.exp     = hold_exp;
        out_quot.quot    = quot;
        out_quot.sticky  = (rem != '0);
        out_quot.special = hold_special;
        out_quot.tag     = hold_tag;
    end

endmodule

// File: source/fdiv_normalize.sv
`timescale 1ns/1ns

module fdiv_normalize
    import fdiv_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    input  logic       in_valid,
    output logic       in_ready,
    input  fdiv_quot_t in_quot,

    output logic       out_valid,
    input  logic       out_ready,
    output fdiv_resp_t out_resp
);

    logic [26:0]       q_norm;
    logic signed [9:0] exp_norm, exp_round;
    logic [23:0]       mant;
    logic              guard, sticky_all, round_up;
    logic [24:0]       mant_round;
    logic [22:0]       frac;
    fdiv_resp_t        next_resp;

    always_comb begin
        // Quotient lies in [0.5, 2); bring the leading one to bit 26.
        if (in_quot.quot[26]) begin
            q_norm   = in_quot.quot;
            exp_norm = in_quot.exp;
        end else begin
            q_norm   = {in_quot.quot[25:0], 1'b0};
            exp_norm = in_quot.exp - 10'sd1;
        end

        mant       = q_norm[26:3];
        guard      = q_norm[2];
        sticky_all = (q_norm[1:0] != '0) || in_quot.sticky;

        // Nearest even.
        round_up   = guard && (sticky_all || mant[0]);
        mant_round = {1'b0, mant} + 25'(round_up);
        exp_round  = exp_norm + 10'(mant_round[24]);
        // A carry-out leaves the fraction bits at zero.
        frac       = mant_round[22:0];
    end

    always_comb begin
        next_resp.tag   = in_quot.tag;
        next_resp.flags = '0;

        case (in_quot.special)
            SPECIAL_NAN_INVALID: begin
                next_resp.result        = CANONICAL_NAN;
                next_resp.flags.invalid = 1'b1;
            end
            SPECIAL_NAN_QUIET: begin
                next_resp.result = CANONICAL_NAN;
            end
            SPECIAL_INF: begin
                next_resp.result = {in_quot.sign, 8'hff, 23'd0};
            end
            SPECIAL_DIV_ZERO: begin
                next_resp.result         = {in_quot.sign, 8'hff, 23'd0};
                next_resp.flags.div_zero = 1'b1;
            end
            SPECIAL_ZERO: begin
                next_resp.result = {in_quot.sign, 31'd0};
            end
            default: begin
                if (exp_round >= EXP_MAX) begin
                    next_resp.result         = {in_quot.sign, 8'hff, 23'd0};
                    next_resp.flags.overflow = 1'b1;
                    next_resp.flags.inexact  = 1'b1;
                end else if (exp_round <= 10'sd0) begin
                    // Flush to zero.
                    next_resp.result          = {in_quot.sign, 31'd0};
                    next_resp.flags.underflow = 1'b1;
                    next_resp.flags.inexact   = 1'b1;
                end else begin
                    next_resp.result        = {in_quot.sign, exp_round[7:0], frac};
                    next_resp.flags.inexact = guard || sticky_all;
                end
            end
        endcase
    end

    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end

        if (in_valid && in_ready) begin
            out_resp <= next_resp;
        end
    end

endmodule

// File: source/fdiv_output_stage.sv
`timescale 1ns/1ns

module fdiv_output_stage
    import fdiv_pkg::*;
#(
    parameter int OUTPUT_REGISTER = 1
)(
    input  logic       clk,
    input  logic       rst,

    input  logic       in_valid,
    output logic       in_ready,
    input  fdiv_resp_t in_resp,

    output logic       out_valid,
    input  logic       out_ready,
    output fdiv_resp_t out_resp
);

    generate
        if (OUTPUT_REGISTER != 0) begin : g_skid
            logic       main_valid, spare_valid;
            fdiv_resp_t main_resp, spare_resp;

            // Only a full spare entry stalls the upstream stage.
            assign in_ready  = !spare_valid;
            assign out_valid = main_valid;
            assign out_resp  = main_resp;

            always_ff @(posedge clk) begin
                if (rst) begin
                    main_valid  <= 1'b0;
                    spare_valid <= 1'b0;
                end else if (out_ready || !main_valid) begin
                    if (spare_valid) begin
                        main_resp   <= spare_resp;
                        spare_valid <= 1'b0;
                    end else begin
                        main_valid <= in_valid;
                        main_resp  <= in_resp;
                    end
                end else if (in_valid && !spare_valid) begin
                    spare_resp  <= in_resp;
                    spare_valid <= 1'b1;
                end
            end
        end else begin : g_bypass
            assign in_ready  = out_ready;
            assign out_valid = in_valid;
            assign out_resp  = in_resp;
        end
    endgenerate

endmodule

// File: source/fdiv_pkg.sv
package fdiv_pkg;

    localparam int TAG_WIDTH = 5;

    // Number of shift-and-subtract steps: 24 mantissa bits, guard, round and one
    // extra bit for quotients below 1.0.
    localparam int ITER_STEPS = 27;

    localparam logic signed [9:0] EXP_BIAS = 10'sd127;
    localparam logic signed [9:0] EXP_MAX = 10'sd255;

    localparam logic [31:0] CANONICAL_NAN = 32'h7fc00000;

    typedef enum logic [2:0] {
        SPECIAL_NONE,
        SPECIAL_NAN_INVALID,
        SPECIAL_NAN_QUIET,
        SPECIAL_INF,
        SPECIAL_DIV_ZERO,
        SPECIAL_ZERO
    } fdiv_special_e;

    // Same bit order as the RISC-V fflags CSR.
    typedef struct packed {
        logic invalid;
        logic div_zero;
        logic overflow;
        logic underflow;
        logic inexact;
    } fdiv_flags_t;

    typedef struct packed {
        logic [31:0]          a;
        logic [31:0]          b;
        logic [TAG_WIDTH-1:0] tag;
    } fdiv_req_t;

    typedef struct packed {
        logic                 sign;
        logic signed [9:0]    exp;
        logic [23:0]          mant_a;
        logic [23:0]          mant_b;
        fdiv_special_e        special;
        logic [TAG_WIDTH-1:0] tag;
    } fdiv_exp_t;

    typedef struct packed {
        logic                 sign;
        logic signed [9:0]    exp;
        logic [26:0]          quot;
        logic                 sticky;
        fdiv_special_e        special;
        logic [TAG_WIDTH-1:0] tag;
    } fdiv_quot_t;

    typedef struct packed {
        logic [31:0]          result;
        fdiv_flags_t          flags;
        logic [TAG_WIDTH-1:0] tag;
    } fdiv_resp_t;

endpackage

// File: source/fdiv_unit.sv
`timescale 1ns/1ns

module fdiv_unit
    import fdiv_pkg::*;
#(
    parameter int OUTPUT_REGISTER = 1
)(
    input  logic       clk,
    input  logic       rst,

    input  logic       in_valid,
    output logic       in_ready,
    input  fdiv_req_t  in_req,

    output logic       out_valid,
    input  logic       out_ready,
    output fdiv_resp_t out_resp
);

    logic       exp_valid, exp_ready;
    fdiv_exp_t  exp_data;

    logic       quot_valid, quot_ready;
    fdiv_quot_t quot_data;

    logic       norm_valid, norm_ready;
    fdiv_resp_t norm_data;

    fdiv_exponent exponent_inst (
        .clk, .rst,
        .in_valid, .in_ready, .in_req,
        .out_valid(exp_valid), .out_ready(exp_ready), .out_exp(exp_data)
    );

    fdiv_iterate iterate_inst (
        .clk, .rst,
        .in_valid(exp_valid), .in_ready(exp_ready), .in_exp(exp_data),
        .out_valid(quot_valid), .out_ready(quot_ready), .out_quot(quot_data)
    );

    fdiv_normalize normalize_inst (
        .clk, .rst,
        .in_valid(quot_valid), .in_ready(quot_ready), .in_quot(quot_data),
        .out_valid(norm_valid), .out_ready(norm_ready), .out_resp(norm_data)
    );

    fdiv_output_stage #(
        .OUTPUT_REGISTER(OUTPUT_REGISTER)
    ) output_stage_inst (
        .clk, .rst,
        .in_valid(norm_valid), .in_ready(norm_ready), .in_resp(norm_data),
        .out_valid, .out_ready, .out_resp
    );

endmodule
